/* hw/core_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Core package
// Opcodes, controller states and the structs shared by the
// instruction core and its sleep unit
//////////////////////////////////////////////////////////////////////

package core_pkg;

  // Width of the immediate operand carried by every instruction
  localparam int unsigned OPERAND_W = 8;

  // Supported opcodes
  typedef enum logic [1:0] {
    OP_NOP  = 2'b00,
    OP_OUT  = 2'b01,
    OP_WAIT = 2'b10,
    OP_WFI  = 2'b11
  } op_e;

  // Controller FSM states
  typedef enum logic [1:0] {
    RESET      = 2'b00,
    RUN        = 2'b01,
    WAIT_SLEEP = 2'b10,
    SLEEP      = 2'b11
  } ctrl_state_e;

  // Instruction word as stored in the buffer
  typedef struct packed {
    op_e                  op;
    logic [OPERAND_W-1:0] operand;
  } instr_t;

  // Busy flags of the gated units, collected for the sleep unit
  typedef struct packed {
    logic if_busy;
    logic ctrl_busy;
  } busy_t;

endpackage : core_pkg

/* hw/clock_gate.sv */
//////////////////////////////////////////////////////////////////////
// Clock gate
// Latch based glitch free gate with functional and scan enables
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic scan_cg_en_i,
  output logic clk_o
);

  // Enable held stable through the high phase of the clock
  logic en_latch;

  // Transparent while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | scan_cg_en_i;
    end
  end

  // High phase only passes when the latched enable was set
  assign clk_o = clk_i & en_latch;

endmodule : clock_gate

/* hw/sleep_unit.sv */
//////////////////////////////////////////////////////////////////////
// Sleep unit
// Keeps the sticky fetch enable and the registered core busy state,
// derives the core clock enable and reports sleep
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sleep_unit (
  // Free running clock and reset
  input  logic                clk_ungated_i,
  input  logic                rst_n,
  input  logic                scan_cg_en_i,
  output logic                clk_gated_o,
  // Fetch enable, pulse or level in, sticky out
  input  logic                fetch_enable_i,
  output logic                fetch_enable_o,
  // Wake level and busy flags of the gated units
  input  logic                wake_from_sleep_i,
  input  core_pkg::busy_t     busy_i,
  output logic                core_sleep_o
);

  logic fetch_enable_q;
  logic fetch_enable_d;
  logic core_busy_q;
  logic core_busy_d;
  logic clock_en;

  //////////////////////////////////////////////////////////////////////
  // Enable and sleep logic
  //////////////////////////////////////////////////////////////////////

  // Fetch enable stays set once seen
  assign fetch_enable_d = fetch_enable_i | fetch_enable_q;

  // Any unit still working keeps the clock running
  assign core_busy_d = busy_i.if_busy | busy_i.ctrl_busy;

  // Clock only after fetch enable, while busy or when woken
  assign clock_en = fetch_enable_q & (wake_from_sleep_i | core_busy_q);

  // Sleeping means enabled but clock stopped
  assign core_sleep_o = fetch_enable_q & ~clock_en;

  always_ff @(posedge clk_ungated_i or negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_d;
      core_busy_q    <= core_busy_d;
    end
  end

  assign fetch_enable_o = fetch_enable_q;

  // Single gate for fetch unit, buffer and controller
  clock_gate core_clock_gate_i (
    .clk_i        (clk_ungated_i),
    .en_i         (clock_en),
    .scan_cg_en_i (scan_cg_en_i),
    .clk_o        (clk_gated_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Gate passes no functional edge before the first fetch enable
  a_no_clock_before_fetch : assert property (@(posedge clk_gated_o) disable iff (!rst_n)
    !scan_cg_en_i |-> fetch_enable_q);

  // Only scan edges reach the core while it sleeps
  a_stable_in_sleep : assert property (@(posedge clk_gated_o) disable iff (!rst_n)
    !scan_cg_en_i |-> !core_sleep_o);

  // Gated units report idle for the whole sleep
  a_idle_in_sleep : assert property (@(posedge clk_ungated_i) disable iff (!rst_n)
    core_sleep_o |-> !busy_i.if_busy && !busy_i.ctrl_busy);

endmodule : sleep_unit

/* hw/fetch_unit.sv */
//////////////////////////////////////////////////////////////////////
// Fetch unit
// Captures strobed instruction words and forwards them to the
// instruction buffer through a one word holding register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk_i,
  input  logic             rst_n,
  // Instruction source
  input  logic             instr_valid_i,
  input  core_pkg::instr_t instr_i,
  output logic             instr_stall_o,
  // Buffer write side
  input  logic             buf_full_i,
  output logic             buf_wr_o,
  output core_pkg::instr_t buf_wdata_o,
  // Status toward the sleep unit
  output logic             if_busy_o
);

  logic             hold_valid_q;
  logic             hold_valid_d;
  core_pkg::instr_t hold_q;

  // Held word goes first, else a new word passes straight through
  assign buf_wr_o    = hold_valid_q ? !buf_full_i : (instr_valid_i && !buf_full_i);
  assign buf_wdata_o = hold_valid_q ? hold_q : instr_i;

  // Occupied until the buffer has room, or filled by a strobe on a full buffer
  assign hold_valid_d = hold_valid_q ? buf_full_i : (instr_valid_i && buf_full_i);

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= hold_valid_d;
    end
  end

  // Payload only, loaded when a word cannot go straight in
  always_ff @(posedge clk_i) begin
    if (!hold_valid_q && instr_valid_i && buf_full_i) begin
      hold_q <= instr_i;
    end
  end

  // Back pressure toward the source
  assign instr_stall_o = hold_valid_q;
  assign if_busy_o     = hold_valid_q;

  // Source must honour the stall, otherwise a word would be lost
  a_no_strobe_on_stall : assert property (@(posedge clk_i) disable iff (!rst_n)
    instr_valid_i |-> !hold_valid_q);

endmodule : fetch_unit

/* hw/instr_buffer.sv */
//////////////////////////////////////////////////////////////////////
// Instruction buffer
// Synchronous circular FIFO of instruction words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_buffer #(
  parameter int unsigned BUF_DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_n,
  // Write side
  input  logic             wr_i,
  input  core_pkg::instr_t wdata_i,
  output logic             full_o,
  // Read side, head word always visible
  input  logic             rd_i,
  output core_pkg::instr_t rdata_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);
  localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(BUF_DEPTH);

  core_pkg::instr_t mem [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Power of two depth, pointers wrap by overflow
      if (wr_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous read and write leaves the level unchanged
      if (wr_i && !rd_i) begin
        count_q <= count_q + 1'b1;
      end else if (rd_i && !wr_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem[rd_ptr_q];
  assign full_o  = (count_q == DEPTH_C);
  assign empty_o = (count_q == '0);

  // Producer and consumer must both look at the flags
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_n)
    wr_i |-> !full_o);
  a_no_read_empty : assert property (@(posedge clk_i) disable iff (!rst_n)
    rd_i |-> !empty_o);

endmodule : instr_buffer

/* hw/core_controller.sv */
//////////////////////////////////////////////////////////////////////
// Core controller
// Pops instructions from the buffer and executes NOP, OUT, WAIT
// and WFI, including sleep entry and wake up
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_controller (
  input  logic                           clk_i,
  input  logic                           rst_n,
  // From the sleep unit and the outside world
  input  logic                           fetch_enable_i,
  input  logic                           irq_i,
  // Buffer read side
  input  logic                           buf_empty_i,
  input  core_pkg::instr_t               buf_rdata_i,
  output logic                           buf_rd_o,
  // Fetch status, needed before going to sleep
  input  logic                           if_busy_i,
  output logic                           ctrl_busy_o,
  // Result port
  output logic                           out_valid_o,
  output logic [core_pkg::OPERAND_W-1:0] out_data_o
);

  core_pkg::ctrl_state_e state_q;
  core_pkg::ctrl_state_e state_d;

  logic [core_pkg::OPERAND_W-1:0] wait_cnt_q;
  logic [core_pkg::OPERAND_W-1:0] wait_cnt_d;
  logic                           pop_out;
  logic                           out_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    wait_cnt_d = wait_cnt_q;
    buf_rd_o   = 1'b0;
    case (state_q)
      core_pkg::RESET: begin
        // Leave reset once fetching is allowed
        if (fetch_enable_i) begin
          state_d = core_pkg::RUN;
        end
      end
      core_pkg::RUN: begin
        if (wait_cnt_q != '0) begin
          // Still counting down a WAIT, no pop
          wait_cnt_d = wait_cnt_q - 1'b1;
        end else if (!buf_empty_i) begin
          buf_rd_o = 1'b1;
          case (buf_rdata_i.op)
            core_pkg::OP_WAIT: wait_cnt_d = buf_rdata_i.operand;
            core_pkg::OP_WFI:  state_d    = core_pkg::WAIT_SLEEP;
            // NOP and OUT keep the state, OUT is handled below
            default: ;
          endcase
        end
      end
      core_pkg::WAIT_SLEEP: begin
        // A word still in the holding register must reach the buffer first
        if (!if_busy_i) begin
          state_d = core_pkg::SLEEP;
        end
      end
      core_pkg::SLEEP: begin
        if (irq_i) begin
          state_d = core_pkg::RUN;
        end
      end
      default: state_d = core_pkg::RESET;
    endcase
  end

  // OUT popped this cycle
  assign pop_out = buf_rd_o && (buf_rdata_i.op == core_pkg::OP_OUT);

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= core_pkg::RESET;
      wait_cnt_q  <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      wait_cnt_q  <= wait_cnt_d;
      out_valid_q <= pop_out;
    end
  end

  // Result data, loaded with the operand on the OUT pop
  always_ff @(posedge clk_i) begin
    if (pop_out) begin
      out_data_o <= buf_rdata_i.operand;
    end
  end

  assign out_valid_o = out_valid_q;

  // Idle only on the way into sleep and during it
  assign ctrl_busy_o = (state_q != core_pkg::WAIT_SLEEP) && (state_q != core_pkg::SLEEP);

endmodule : core_controller

/* hw/core_top.sv */
//////////////////////////////////////////////////////////////////////
// Core top
// Small in order instruction core with a sleep unit gating the
// clock of fetch, buffer and controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_top #(
  parameter int unsigned BUF_DEPTH = 4
) (
  input  logic                           clk_ungated_i,
  input  logic                           rst_n,
  input  logic                           scan_cg_en_i,
  input  logic                           fetch_enable_i,
  input  logic                           instr_valid_i,
  input  core_pkg::instr_t               instr_i,
  input  logic                           irq_i,
  output logic                           clk_gated_o,
  output logic                           core_sleep_o,
  output logic                           fetch_enable_o,
  output logic                           instr_stall_o,
  output logic                           out_valid_o,
  output logic [core_pkg::OPERAND_W-1:0] out_data_o
);

  logic             if_busy;
  logic             ctrl_busy;
  core_pkg::busy_t  busy;
  logic             buf_wr;
  logic             buf_rd;
  logic             buf_full;
  logic             buf_empty;
  core_pkg::instr_t buf_wdata;
  core_pkg::instr_t buf_rdata;

  // Busy flags travel to the sleep unit as one struct
  assign busy.if_busy   = if_busy;
  assign busy.ctrl_busy = ctrl_busy;

  // Runs on the free clock
  sleep_unit sleep_unit_i (
    .clk_ungated_i     (clk_ungated_i),
    .rst_n             (rst_n),
    .scan_cg_en_i      (scan_cg_en_i),
    .clk_gated_o       (clk_gated_o),
    .fetch_enable_i    (fetch_enable_i),
    .fetch_enable_o    (fetch_enable_o),
    .wake_from_sleep_i (irq_i),
    .busy_i            (busy),
    .core_sleep_o      (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Gated clock domain
  //////////////////////////////////////////////////////////////////////

  fetch_unit fetch_unit_i (
    .clk_i         (clk_gated_o),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_stall_o (instr_stall_o),
    .buf_full_i    (buf_full),
    .buf_wr_o      (buf_wr),
    .buf_wdata_o   (buf_wdata),
    .if_busy_o     (if_busy)
  );

  instr_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) instr_buffer_i (
    .clk_i   (clk_gated_o),
    .rst_n   (rst_n),
    .wr_i    (buf_wr),
    .wdata_i (buf_wdata),
    .full_o  (buf_full),
    .rd_i    (buf_rd),
    .rdata_o (buf_rdata),
    .empty_o (buf_empty)
  );

  core_controller core_controller_i (
    .clk_i          (clk_gated_o),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_o),
    .irq_i          (irq_i),
    .buf_empty_i    (buf_empty),
    .buf_rdata_i    (buf_rdata),
    .buf_rd_o       (buf_rd),
    .if_busy_i      (if_busy),
    .ctrl_busy_o    (ctrl_busy),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o)
  );

endmodule : core_top

/* tests/tb_core.sv */
//////////////////////////////////////////////////////////////////////
// Core testbench
// Streams instruction words into the core and checks results, WAIT
// spacing, sleep, wake and scan clocking with assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core;

  // Whole run is a few hundred cycles, eight times that is the limit
  localparam int MAX_CYCLES = 3000;

  // Expected result and the least spacing after the previous result
  typedef struct packed {
    logic [core_pkg::OPERAND_W-1:0] data;
    int                             gap;
  } expect_t;

  logic                           clk;
  logic                           rst_n;
  logic                           scan_cg_en;
  logic                           fetch_enable;
  logic                           instr_valid;
  core_pkg::instr_t               instr_word;
  logic                           irq;
  logic                           clk_gated;
  logic                           core_sleep;
  logic                           fetch_enable_out;
  logic                           instr_stall;
  logic                           out_valid;
  logic [core_pkg::OPERAND_W-1:0] out_data;

  expect_t expected[$];
  integer  seed;
  int      cycle_cnt = 0;
  int      pending_gap = 0;
  int      last_out_cycle = 0;
  int      stall_cycles = 0;
  int      scan_edges = 0;
  int      value_errs = 0;
  int      state_errs = 0;
  int      clock_errs = 0;
  int      seq_errs = 0;
  logic    have_prev = 1'b0;
  logic    fe_driven = 1'b0;
  logic    sleep_hold = 1'b0;
  logic    sleep_at_neg = 1'b0;
  logic    scan_at_neg = 1'b0;

  core_top #(
    .BUF_DEPTH (4)
  ) dut_i (
    .clk_ungated_i  (clk),
    .rst_n          (rst_n),
    .scan_cg_en_i   (scan_cg_en),
    .fetch_enable_i (fetch_enable),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr_word),
    .irq_i          (irq),
    .clk_gated_o    (clk_gated),
    .core_sleep_o   (core_sleep),
    .fetch_enable_o (fetch_enable_out),
    .instr_stall_o  (instr_stall),
    .out_valid_o    (out_valid),
    .out_data_o     (out_data)
  );

  // 20 ns free running clock
  always #10 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the core stopped making progress", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  // Mid cycle snapshot, read on gated edges
  always @(negedge clk) begin
    sleep_at_neg <= core_sleep;
    scan_at_neg  <= scan_cg_en;
    if (instr_stall) begin
      stall_cycles <= stall_cycles + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Gated clock only runs after fetch enable, and not in sleep without scan
  always @(posedge clk_gated) begin
    if (scan_at_neg) begin
      scan_edges <= scan_edges + 1;
    end
    assert (fe_driven || scan_at_neg) else begin
      clock_errs++;
      $display("Gated clock rose before fetch enable at cycle %0d", cycle_cnt);
    end
    assert (!sleep_at_neg || scan_at_neg) else begin
      clock_errs++;
      $display("Gated clock rose during sleep at cycle %0d", cycle_cnt);
    end
  end

  always @(negedge clk) begin : check_outputs
    expect_t e;
    if (rst_n) begin
      if (!fe_driven) begin
        assert (!core_sleep && !fetch_enable_out && !out_valid) else begin
          state_errs++;
          $display("Core left its idle state before fetch enable");
        end
      end
      // Wake level drops sleep in the same cycle
      assert (!(irq && core_sleep)) else begin
        state_errs++;
        $display("Sleep still reported while the wake level is high");
      end
      assert (!(core_sleep && out_valid)) else begin
        state_errs++;
        $display("Result strobe seen during sleep");
      end
      // Sleep holds until the wake level arrives, scan or not
      assert (!sleep_hold || core_sleep) else begin
        state_errs++;
        $display("Core left sleep without a wake level");
      end
      if (out_valid) begin
        assert (expected.size() != 0) else begin
          state_errs++;
          $display("Result strobe with no OUT word outstanding");
        end
        if (expected.size() != 0) begin
          e = expected.pop_front();
          assert (out_data == e.data) else begin
            value_errs++;
            $display("Error: out_data_o is %h, expected %h", out_data, e.data);
          end
          assert (!have_prev || (cycle_cnt - last_out_cycle) >= e.gap) else begin
            state_errs++;
            $display("Result came %0d cycles after the previous one, WAIT asks for %0d",
                     cycle_cnt - last_out_cycle, e.gap);
          end
        end
        have_prev      = 1'b1;
        last_out_cycle = cycle_cnt;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Source side helpers
  //////////////////////////////////////////////////////////////////////

  function automatic core_pkg::instr_t make_instr(input core_pkg::op_e op,
                                                  input logic [core_pkg::OPERAND_W-1:0] operand);
    core_pkg::instr_t w;
    w.op      = op;
    w.operand = operand;
    return w;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One strobe, only while neither stalled nor asleep
  task automatic send_word(input core_pkg::instr_t w);
    @(negedge clk);
    while (instr_stall || core_sleep) begin
      @(negedge clk);
    end
    @(posedge clk);
    instr_valid <= 1'b1;
    instr_word  <= w;
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  // Reference entry goes in when the word is issued
  task automatic queue_out(input logic [core_pkg::OPERAND_W-1:0] data);
    expect_t e;
    e.data      = data;
    e.gap       = pending_gap;
    pending_gap = 0;
    expected.push_back(e);
    send_word(make_instr(core_pkg::OP_OUT, data));
  endtask

  task automatic stall_core(input int n);
    pending_gap += n;
    send_word(make_instr(core_pkg::OP_WAIT, core_pkg::OPERAND_W'(n)));
  endtask

  task automatic await_sleep;
    @(negedge clk);
    while (!core_sleep) begin
      @(negedge clk);
    end
    @(posedge clk);
    sleep_hold <= 1'b1;
  endtask

  // Wake level held until the core reports busy again
  task automatic wake_core;
    @(posedge clk);
    irq        <= 1'b1;
    sleep_hold <= 1'b0;
    idle_cycles(4);
    @(posedge clk);
    irq <= 1'b0;
  endtask

  task automatic drain_outputs;
    @(negedge clk);
    while (expected.size() != 0) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int k;
    int start_edges;
    seed         = 32'h4089;
    clk          = 1'b0;
    rst_n        = 1'b0;
    scan_cg_en   = 1'b0;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    instr_word   = '0;
    irq          = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Idle core, then a single fetch enable pulse
    idle_cycles(6);
    @(posedge clk);
    fetch_enable <= 1'b1;
    fe_driven    <= 1'b1;
    @(posedge clk);
    fetch_enable <= 1'b0;
    @(negedge clk);
    while (!fetch_enable_out) begin
      @(negedge clk);
    end
    idle_cycles(2);

    // Burst behind a WAIT so the buffer fills and stalls the source
    stall_core(12);
    for (k = 0; k < 15; k++) begin
      if (($random(seed) & 3) == 0) begin
        send_word(make_instr(core_pkg::OP_NOP, core_pkg::OPERAND_W'($random(seed))));
      end else begin
        queue_out(core_pkg::OPERAND_W'($random(seed)));
      end
    end
    queue_out(core_pkg::OPERAND_W'($random(seed)));
    drain_outputs();
    assert (stall_cycles > 0) else begin
      seq_errs++;
      $display("Buffer never pushed back on the source");
    end

    // OUT pairs around random WAIT lengths
    for (k = 0; k < 4; k++) begin
      queue_out(core_pkg::OPERAND_W'($random(seed)));
      stall_core(3 + ($random(seed) & 15));
      queue_out(core_pkg::OPERAND_W'($random(seed)));
    end
    drain_outputs();

    // WFI with nothing behind it
    send_word(make_instr(core_pkg::OP_WFI, '0));
    await_sleep();
    idle_cycles(8);
    wake_core();
    idle_cycles(4);

    // WFI held back by a WAIT, two results left buffered across sleep
    stall_core(10);
    send_word(make_instr(core_pkg::OP_WFI, '0));
    queue_out(core_pkg::OPERAND_W'($random(seed)));
    queue_out(core_pkg::OPERAND_W'($random(seed)));
    await_sleep();
    idle_cycles(3);

    // Scan clocking while asleep
    start_edges = scan_edges;
    @(posedge clk);
    scan_cg_en <= 1'b1;
    idle_cycles(6);
    @(posedge clk);
    scan_cg_en <= 1'b0;
    idle_cycles(3);
    assert (scan_edges > start_edges) else begin
      seq_errs++;
      $display("Gated clock did not toggle under scan enable");
    end
    wake_core();
    drain_outputs();
    idle_cycles(20);

    $display("Errors: %0d value, %0d state, %0d clock, %0d sequence",
             value_errs, state_errs, clock_errs, seq_errs);
    if (value_errs + state_errs + clock_errs + seq_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_core

/* all.f */
hw/core_pkg.sv
hw/clock_gate.sv
hw/sleep_unit.sv
hw/fetch_unit.sv
hw/instr_buffer.sv
hw/core_controller.sv
hw/core_top.sv
tests/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile the core and its testbench with Verilator, run, check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core -Mdir obj_dir -f all.f

./obj_dir/Vtb_core | tee sim.log

# Pass only when the testbench reported a clean run
grep -q "All tests passed!" sim.log
echo "Simulation passed"
